//--- all.f
src/la_pkg.sv
src/div_unit.sv
src/data_ram.sv
src/ex_stage.sv
src/mem_wb_stage.sv
src/ex_top.sv
dv/ex_top_assert.sv
dv/tb_ex_top.sv

//--- Bender.yml
package:
  name: ex_top

sources:
  - src/la_pkg.sv
  - src/div_unit.sv
  - src/data_ram.sv
  - src/ex_stage.sv
  - src/mem_wb_stage.sv
  - src/ex_top.sv
  - target: test
    files:
      - dv/ex_top_assert.sv
      - dv/tb_ex_top.sv

//--- dv/tb_ex_top.sv
`timescale 1ns/1ps

module tb_ex_top;

    import la_pkg::*;

    localparam int unsigned ram_words  = 256;
    localparam int          max_cycles = 3000;
    localparam int          alu_lat    = 2;
    localparam int          div_lat    = 35;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       issue_valid;
    aluop_e     aluop;
    bus32_t     reg1;
    bus32_t     reg2;
    bus32_t     imm;
    logic [4:0] rd;
    logic       busy;
    logic       wb_valid;
    logic [4:0] wb_rd;
    bus32_t     wb_data;
    logic       exc_valid;
    exc_cause_e exc_cause;

    int         errors = 0;
    int         cycle  = 0;
    int         seed_val;
    bus32_t     mirror [ram_words];
    logic       model_llb;
    logic [4:0] exp_rd [$];
    bus32_t     exp_data [$];
    logic       exp_fault [$];
    int         exp_cycle [$];

    ex_top #(
        .ram_words (ram_words)
    ) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .aluop       (aluop),
        .reg1        (reg1),
        .reg2        (reg2),
        .imm         (imm),
        .rd          (rd),
        .busy        (busy),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .exc_valid   (exc_valid),
        .exc_cause   (exc_cause)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles) begin
            $display("Timeout after %0d cycles, %0d results still outstanding",
                     cycle, exp_rd.size());
            $display("TEST FAILED");
            $finish;
        end
    end

    // Writeback is compared at the falling edge, in issue order.
    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            if (exp_rd.size() == 0) begin
                errors++;
                $display("Writeback at cycle %0d with no operation outstanding", cycle);
            end else begin
                if (cycle != exp_cycle[0]) begin
                    errors++;
                    $display("Writeback came at cycle %0d instead of cycle %0d",
                             cycle, exp_cycle[0]);
                end
                if (wb_rd !== exp_rd[0]) begin
                    errors++;
                    $display("Error wb_rd: got %h, expected %h", wb_rd, exp_rd[0]);
                end
                if (wb_data !== exp_data[0]) begin
                    errors++;
                    $display("Error wb_data: got %h, expected %h", wb_data, exp_data[0]);
                end
                if (exc_valid !== exp_fault[0]) begin
                    errors++;
                    $display("Error exc_valid: got %h, expected %h", exc_valid, exp_fault[0]);
                end
                if (exc_cause !== (exp_fault[0] ? EXC_ALE : EXC_NONE)) begin
                    errors++;
                    $display("Error exc_cause: got %h, expected %h", exc_cause,
                             exp_fault[0] ? EXC_ALE : EXC_NONE);
                end
                exp_rd.delete(0);
                exp_data.delete(0);
                exp_fault.delete(0);
                exp_cycle.delete(0);
            end
        end
    end

    function automatic bus32_t alu_model(aluop_e op, bus32_t a, bus32_t b);
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        bus64_t          prod;
        sa = $signed(a);
        sb = $signed(b);
        ua = a;
        ub = b;
        case (op)
            ALU_OR:    return a | b;
            ALU_NOR:   return ~(a | b);
            ALU_AND:   return a & b;
            ALU_XOR:   return a ^ b;
            ALU_SLL:   return a << b[4:0];
            ALU_SRL:   return a >> b[4:0];
            ALU_SRA:   return $signed(a) >>> b[4:0];
            ALU_ADD:   return a + b;
            ALU_SUB:   return a - b;
            ALU_SLT:   return (sa < sb) ? 32'd1 : 32'd0;
            ALU_SLTU:  return (ua < ub) ? 32'd1 : 32'd0;
            ALU_MUL:   return a * b;
            ALU_MULH: begin
                prod = sa * sb;
                return prod[63:32];
            end
            ALU_MULHU: begin
                prod = ua * ub;
                return prod[63:32];
            end
            default:   return 32'd0;
        endcase
    endfunction

    function automatic bus32_t div_model(aluop_e op, bus32_t a, bus32_t b);
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        bus64_t          res;
        sa = $signed(a);
        sb = $signed(b);
        ua = a;
        ub = b;
        // Zero divisor gives an all-ones quotient and keeps the dividend.
        if (b == 32'd0) begin
            return (op == ALU_DIV || op == ALU_DIVU) ? 32'hffff_ffff : a;
        end
        case (op)
            ALU_DIV:  res = sa / sb;
            ALU_MOD:  res = sa % sb;
            ALU_DIVU: res = ua / ub;
            default:  res = ua % ub;
        endcase
        return res[31:0];
    endfunction

    function automatic int word_index(bus32_t addr);
        return (addr >> 2) % ram_words;
    endfunction

    function automatic bus32_t aligned_addr(aluop_e op, bus32_t addr);
        case (op)
            ALU_LDH, ALU_LDHU, ALU_STH: return {addr[31:1], 1'b0};
            ALU_LDW, ALU_LLW, ALU_STW, ALU_SCW: return {addr[31:2], 2'b00};
            default: return addr;
        endcase
    endfunction

    function automatic bus32_t load_value(aluop_e op, bus32_t addr);
        bus32_t      word;
        logic [7:0]  b;
        logic [15:0] h;
        word = mirror[word_index(addr)];
        b    = word[8*addr[1:0] +: 8];
        h    = addr[1] ? word[31:16] : word[15:0];
        case (op)
            ALU_LDB:  return {{24{b[7]}}, b};
            ALU_LDBU: return {24'd0, b};
            ALU_LDH:  return {{16{h[15]}}, h};
            ALU_LDHU: return {16'd0, h};
            default:  return word;
        endcase
    endfunction

    function automatic void mirror_write(aluop_e op, bus32_t addr, bus32_t data);
        int idx;
        idx = word_index(addr);
        case (op)
            ALU_STB: mirror[idx][8*addr[1:0] +: 8] = data[7:0];
            ALU_STH: mirror[idx][16*addr[1] +: 16] = data[15:0];
            default: mirror[idx] = data;
        endcase
    endfunction

    task automatic issue_op(input aluop_e op, input bus32_t a, input bus32_t b,
                            input bus32_t offs, input logic [4:0] dst, input bus32_t value,
                            input logic fault, input int lat);
        @(posedge clk);
        issue_valid <= 1'b1;
        aluop       <= op;
        reg1        <= a;
        reg2        <= b;
        imm         <= offs;
        rd          <= dst;
        exp_rd.push_back(dst);
        exp_data.push_back(value);
        exp_fault.push_back(fault);
        // The counter still holds the value from before this edge.
        exp_cycle.push_back(cycle + 1 + lat);
    endtask

    task automatic stop_issue();
        @(posedge clk);
        issue_valid <= 1'b0;
        aluop       <= ALU_NOP;
    endtask

    task automatic drain_results();
        while (exp_rd.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // Random base and offset that add up to the wanted address.
    task automatic mem_access(input aluop_e op, input bus32_t addr, input bus32_t data);
        logic        fault;
        logic [11:0] r;
        bus32_t      offs;
        bus32_t      value;
        r     = $urandom;
        offs  = {{20{r[11]}}, r};
        value = 32'd0;
        fault = (aligned_addr(op, addr) != addr);
        if (!fault) begin
            case (op)
                ALU_STB, ALU_STH, ALU_STW: mirror_write(op, addr, data);
                ALU_SCW: begin
                    value = {31'd0, model_llb};
                    if (model_llb) begin
                        mirror_write(ALU_STW, addr, data);
                        model_llb = 1'b0;
                    end
                end
                ALU_LLW: begin
                    value     = load_value(op, addr);
                    model_llb = 1'b1;
                end
                default: value = load_value(op, addr);
            endcase
        end
        issue_op(op, addr - offs, data, offs, $urandom_range(1, 31), value, fault, alu_lat);
    endtask

    task automatic alu_sweep();
        aluop_e ops [14] = '{ALU_OR, ALU_NOR, ALU_AND, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
                             ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_MUL, ALU_MULH, ALU_MULHU};
        bus32_t a;
        bus32_t b;
        for (int round = 0; round < 3; round++) begin
            foreach (ops[i]) begin
                a = $urandom;
                b = $urandom;
                issue_op(ops[i], a, b, 32'd0, $urandom_range(1, 31), alu_model(ops[i], a, b),
                         1'b0, alu_lat);
            end
        end
        issue_op(ALU_SRA, 32'h8000_0000, 32'd31, 32'd0, 5'd3,
                 alu_model(ALU_SRA, 32'h8000_0000, 32'd31), 1'b0, alu_lat);
        issue_op(ALU_SLT, 32'hffff_ffff, 32'd1, 32'd0, 5'd4,
                 alu_model(ALU_SLT, 32'hffff_ffff, 32'd1), 1'b0, alu_lat);
        issue_op(ALU_MULHU, 32'hffff_ffff, 32'hffff_ffff, 32'd0, 5'd5,
                 alu_model(ALU_MULHU, 32'hffff_ffff, 32'hffff_ffff), 1'b0, alu_lat);
        stop_issue();
        drain_results();
    endtask

    task automatic run_divide(input aluop_e op, input bus32_t a, input bus32_t b);
        int busy_cycles;
        busy_cycles = 0;
        issue_op(op, a, b, 32'd0, $urandom_range(1, 31), div_model(op, a, b), 1'b0, div_lat);
        stop_issue();
        do begin
            @(negedge clk);
            if (busy) begin
                busy_cycles++;
            end
        end while (!wb_valid);
        // Busy covers the cycle after issue through the divider's done cycle.
        if (busy_cycles != div_lat - 2) begin
            errors++;
            $display("Error busy_cycles: got %h, expected %h", busy_cycles, div_lat - 2);
        end
    endtask

    task automatic divide_cases();
        run_divide(ALU_DIV, 32'd100, 32'd7);
        run_divide(ALU_DIV, -32'd100, 32'd7);
        run_divide(ALU_DIV, 32'd100, -32'd7);
        run_divide(ALU_MOD, -32'd100, 32'd7);
        run_divide(ALU_MOD, 32'd100, -32'd7);
        run_divide(ALU_MOD, -32'd100, -32'd7);
        run_divide(ALU_DIVU, 32'hffff_fff0, 32'd3);
        run_divide(ALU_MODU, 32'hffff_fff0, 32'd3);
        run_divide(ALU_DIV, 32'h8000_0000, 32'hffff_ffff);
        run_divide(ALU_DIV, -32'd5, 32'd0);
        run_divide(ALU_MOD, -32'd5, 32'd0);
        run_divide(ALU_DIVU, 32'h1234_5678, 32'd0);
        run_divide(ALU_MODU, 32'h1234_5678, 32'd0);
        run_divide(ALU_DIV, $urandom, $urandom);
        run_divide(ALU_MODU, $urandom, $urandom_range(1, 1000));
    endtask

    task automatic store_load_mix();
        aluop_e st_ops [3] = '{ALU_STB, ALU_STH, ALU_STW};
        aluop_e ld_ops [5] = '{ALU_LDB, ALU_LDBU, ALU_LDH, ALU_LDHU, ALU_LDW};
        bus32_t addr [16];
        bus32_t la;
        for (int i = 0; i < 16; i++) begin
            addr[i] = aligned_addr(st_ops[i % 3], $urandom_range(0, 4 * ram_words - 1));
            mem_access(st_ops[i % 3], addr[i], $urandom);
        end
        for (int i = 0; i < 16; i++) begin
            foreach (ld_ops[j]) begin
                la = {addr[i][31:2], 2'(j)};
                mem_access(ld_ops[j], aligned_addr(ld_ops[j], la), 32'd0);
            end
        end
        stop_issue();
        drain_results();
    endtask

    task automatic misaligned_faults();
        bus32_t base;
        base = 4 * $urandom_range(0, ram_words - 1);
        mem_access(ALU_STW, base, $urandom);
        mem_access(ALU_STH, base + 1, $urandom);
        mem_access(ALU_STH, base + 3, $urandom);
        mem_access(ALU_STW, base + 2, $urandom);
        mem_access(ALU_STW, base + 1, $urandom);
        mem_access(ALU_LDH, base + 1, 32'd0);
        mem_access(ALU_LDHU, base + 3, 32'd0);
        mem_access(ALU_LDW, base + 2, 32'd0);
        mem_access(ALU_LLW, base + 1, 32'd0);
        mem_access(ALU_LDW, base, 32'd0);
        mem_access(ALU_LDW, base + 4, 32'd0);
        stop_issue();
        drain_results();
    endtask

    task automatic llsc_sequence();
        bus32_t a;
        bus32_t v;
        a = 4 * $urandom_range(0, ram_words - 1);
        v = $urandom;
        mem_access(ALU_SCW, a, ~v);
        // SC.W right behind LL.W takes the forwarded LLbit.
        mem_access(ALU_LLW, a, 32'd0);
        mem_access(ALU_SCW, a, v);
        mem_access(ALU_SCW, a, ~v);
        mem_access(ALU_LDW, a, 32'd0);
        stop_issue();
        drain_results();
        mem_access(ALU_SCW, a, v ^ 32'h5a5a_5a5a);
        mem_access(ALU_LDW, a, 32'd0);
        mem_access(ALU_LLW, a, 32'd0);
        stop_issue();
        mem_access(ALU_SCW, a, v + 32'd1);
        mem_access(ALU_LDW, a, 32'd0);
        stop_issue();
        drain_results();
    endtask

    initial begin
        seed_val    = $urandom(87);
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        aluop       = ALU_NOP;
        reg1        = 32'd0;
        reg2        = 32'd0;
        imm         = 32'd0;
        rd          = 5'd0;
        model_llb   = 1'b0;
        foreach (mirror[i]) begin
            mirror[i] = 32'd0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        alu_sweep();
        divide_cases();
        store_load_mix();
        misaligned_faults();
        llsc_sequence();
        // A few idle cycles catch any stray writeback.
        repeat (4) @(posedge clk);
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- dv/ex_top_assert.sv
`timescale 1ns/1ps

module ex_top_assert (
    input logic clk,
    input logic rst_n,
    input logic issue_valid,
    input logic busy,
    input logic wb_valid,
    input logic exc_valid,
    input logic div_done
);

    // Outputs stay quiet while reset is held.
    reset_quiet: assert property (@(posedge clk) !rst_n |-> (!wb_valid && !busy))
        else $error("wb_valid or busy high during reset");

    no_issue_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !issue_valid)
        else $error("issue_valid raised while busy");

    exc_with_wb: assert property (@(posedge clk) disable iff (!rst_n)
        exc_valid |-> wb_valid)
        else $error("exc_valid without wb_valid");

    // The divider reports completion for a single cycle.
    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        div_done |=> !div_done)
        else $error("div_done held longer than one cycle");

endmodule

bind ex_top ex_top_assert u_ex_top_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_valid (issue_valid),
    .busy        (busy),
    .wb_valid    (wb_valid),
    .exc_valid   (exc_valid),
    .div_done    (div_done)
);

//--- src/ex_top.sv
`timescale 1ns/1ps

module ex_top #(
    parameter int unsigned ram_words = 256
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue_valid,
    input  la_pkg::aluop_e     aluop,
    input  la_pkg::bus32_t     reg1,
    input  la_pkg::bus32_t     reg2,
    input  la_pkg::bus32_t     imm,
    input  logic [4:0]         rd,
    output logic               busy,
    output logic               wb_valid,
    output logic [4:0]         wb_rd,
    output la_pkg::bus32_t     wb_data,
    output logic               exc_valid,
    output la_pkg::exc_cause_e exc_cause
);

    import la_pkg::*;

    logic       div_start;
    logic       div_signed;
    bus32_t     div_a;
    bus32_t     div_b;
    logic       div_done;
    bus32_t     div_q;
    bus32_t     div_r;

    logic        ram_en;
    logic        ram_we;
    logic [29:0] ram_addr;
    logic [3:0]  ram_wstrb;
    bus32_t      ram_wdata;
    bus32_t      ram_rdata;

    logic        llbit;
    logic        em_valid;
    alusel_e     em_sel;
    aluop_e      em_aluop;
    logic [4:0]  em_rd;
    bus32_t      em_result;
    logic [1:0]  em_byte_off;
    exc_cause_e  em_exc;
    logic        em_llb_we;
    logic        em_llb_val;

    ex_stage u_ex_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .aluop       (aluop),
        .reg1        (reg1),
        .reg2        (reg2),
        .imm         (imm),
        .rd          (rd),
        .busy        (busy),
        .div_start   (div_start),
        .div_signed  (div_signed),
        .div_a       (div_a),
        .div_b       (div_b),
        .div_done    (div_done),
        .div_q       (div_q),
        .div_r       (div_r),
        .ram_en      (ram_en),
        .ram_we      (ram_we),
        .ram_addr    (ram_addr),
        .ram_wstrb   (ram_wstrb),
        .ram_wdata   (ram_wdata),
        .llbit       (llbit),
        .em_valid    (em_valid),
        .em_sel      (em_sel),
        .em_aluop    (em_aluop),
        .em_rd       (em_rd),
        .em_result   (em_result),
        .em_byte_off (em_byte_off),
        .em_exc      (em_exc),
        .em_llb_we   (em_llb_we),
        .em_llb_val  (em_llb_val)
    );

    div_unit u_div_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .div_start  (div_start),
        .div_signed (div_signed),
        .div_a      (div_a),
        .div_b      (div_b),
        .div_done   (div_done),
        .div_q      (div_q),
        .div_r      (div_r)
    );

    data_ram #(
        .ram_words (ram_words)
    ) u_data_ram (
        .clk       (clk),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wstrb (ram_wstrb),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    mem_wb_stage u_mem_wb_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .em_valid    (em_valid),
        .em_sel      (em_sel),
        .em_aluop    (em_aluop),
        .em_rd       (em_rd),
        .em_result   (em_result),
        .em_byte_off (em_byte_off),
        .em_exc      (em_exc),
        .em_llb_we   (em_llb_we),
        .em_llb_val  (em_llb_val),
        .ram_rdata   (ram_rdata),
        .llbit       (llbit),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .exc_valid   (exc_valid),
        .exc_cause   (exc_cause)
    );

endmodule

//--- src/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               em_valid,
    input  la_pkg::alusel_e    em_sel,
    input  la_pkg::aluop_e     em_aluop,
    input  logic [4:0]         em_rd,
    input  la_pkg::bus32_t     em_result,
    input  logic [1:0]         em_byte_off,
    input  la_pkg::exc_cause_e em_exc,
    input  logic               em_llb_we,
    input  logic               em_llb_val,
    input  la_pkg::bus32_t     ram_rdata,
    output logic               llbit,
    output logic               wb_valid,
    output logic [4:0]         wb_rd,
    output la_pkg::bus32_t     wb_data,
    output logic               exc_valid,
    output la_pkg::exc_cause_e exc_cause
);

    import la_pkg::*;

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    bus32_t      ld_data;
    bus32_t      data;
    logic        exc;

    assign ld_byte = ram_rdata[{em_byte_off, 3'b000} +: 8];
    assign ld_half = em_byte_off[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    always_comb begin
        case (em_aluop)
            ALU_LDB:  ld_data = {{24{ld_byte[7]}}, ld_byte};
            ALU_LDBU: ld_data = {24'd0, ld_byte};
            ALU_LDH:  ld_data = {{16{ld_half[15]}}, ld_half};
            ALU_LDHU: ld_data = {16'd0, ld_half};
            default:  ld_data = ram_rdata;
        endcase
    end

    assign data = (em_sel == SEL_LOAD) ? ld_data : em_result;
    assign exc  = (em_exc != EXC_NONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid  <= 1'b0;
            exc_valid <= 1'b0;
            llbit     <= 1'b0;
        end else begin
            wb_valid  <= em_valid;
            exc_valid <= em_valid && exc;
            if (em_valid && em_llb_we && !exc) begin
                llbit <= em_llb_val;
            end
        end
    end

    // A faulting instruction writes back zero.
    always_ff @(posedge clk) begin
        wb_rd     <= em_rd;
        wb_data   <= exc ? 32'd0 : data;
        exc_cause <= em_exc;
    end

endmodule

//--- src/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue_valid,
    input  la_pkg::aluop_e     aluop,
    input  la_pkg::bus32_t     reg1,
    input  la_pkg::bus32_t     reg2,
    input  la_pkg::bus32_t     imm,
    input  logic [4:0]         rd,
    output logic               busy,
    output logic               div_start,
    output logic               div_signed,
    output la_pkg::bus32_t     div_a,
    output la_pkg::bus32_t     div_b,
    input  logic               div_done,
    input  la_pkg::bus32_t     div_q,
    input  la_pkg::bus32_t     div_r,
    output logic               ram_en,
    output logic               ram_we,
    output logic [29:0]        ram_addr,
    output logic [3:0]         ram_wstrb,
    output la_pkg::bus32_t     ram_wdata,
    input  logic               llbit,
    output logic               em_valid,
    output la_pkg::alusel_e    em_sel,
    output la_pkg::aluop_e     em_aluop,
    output logic [4:0]         em_rd,
    output la_pkg::bus32_t     em_result,
    output logic [1:0]         em_byte_off,
    output la_pkg::exc_cause_e em_exc,
    output logic               em_llb_we,
    output logic               em_llb_val
);

    import la_pkg::*;

    typedef enum logic {
        IDLE,
        DIV_WAIT
    } state_e;

    state_e      state;
    aluop_e      div_op;
    logic [4:0]  div_rd;
    alusel_e     sel;
    logic        is_div;
    bus32_t      logic_res;
    bus32_t      shift_res;
    bus32_t      arith_res;
    bus32_t      result;
    logic [4:0]  shamt;
    logic        mul_signed;
    bus64_t      mul_a;
    bus64_t      mul_b;
    bus64_t      product;
    bus32_t      addr;
    logic        ale;
    logic        llb_cur;
    logic        llb_val;
    logic [13:0] csr_waddr;

    always_comb begin
        case (aluop)
            ALU_OR, ALU_NOR, ALU_AND, ALU_XOR: sel = SEL_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA: sel = SEL_SHIFT;
            ALU_LDB, ALU_LDBU, ALU_LDH, ALU_LDHU, ALU_LDW, ALU_LLW: sel = SEL_LOAD;
            ALU_STB, ALU_STH, ALU_STW, ALU_SCW: sel = SEL_STORE;
            default: sel = SEL_ARITH;
        endcase
    end

    always_comb begin
        case (aluop)
            ALU_OR:  logic_res = reg1 | reg2;
            ALU_NOR: logic_res = ~(reg1 | reg2);
            ALU_AND: logic_res = reg1 & reg2;
            ALU_XOR: logic_res = reg1 ^ reg2;
            default: logic_res = 32'd0;
        endcase
    end

    assign shamt = reg2[4:0];

    always_comb begin
        case (aluop)
            ALU_SLL: shift_res = reg1 << shamt;
            ALU_SRL: shift_res = reg1 >> shamt;
            // Vacated upper bits take the sign.
            ALU_SRA: shift_res = (reg1 >> shamt) | ({32{reg1[31]}} & ~(32'hffff_ffff >> shamt));
            default: shift_res = 32'd0;
        endcase
    end

    // Sign-extended 64-bit product, low word is the same either way.
    assign mul_signed = (aluop == ALU_MULH);
    assign mul_a      = mul_signed ? {{32{reg1[31]}}, reg1} : {32'd0, reg1};
    assign mul_b      = mul_signed ? {{32{reg2[31]}}, reg2} : {32'd0, reg2};
    assign product    = mul_a * mul_b;

    always_comb begin
        case (aluop)
            ALU_ADD:   arith_res = reg1 + reg2;
            ALU_SUB:   arith_res = reg1 - reg2;
            ALU_SLT:   arith_res = {31'd0, $signed(reg1) < $signed(reg2)};
            ALU_SLTU:  arith_res = {31'd0, reg1 < reg2};
            ALU_MUL:   arith_res = product[31:0];
            ALU_MULH, ALU_MULHU: arith_res = product[63:32];
            default:   arith_res = 32'd0;
        endcase
    end

    // LLbit from the instruction in the memory stage wins over the register.
    assign llb_cur = em_llb_we ? em_llb_val : llbit;

    assign addr = reg1 + imm;

    always_comb begin
        ram_wdata = reg2;
        ram_wstrb = 4'b1111;
        ale       = 1'b0;
        case (aluop)
            ALU_LDH, ALU_LDHU: ale = addr[0];
            ALU_LDW, ALU_LLW, ALU_STW, ALU_SCW: ale = |addr[1:0];
            ALU_STB: begin
                ram_wdata = {4{reg2[7:0]}};
                ram_wstrb = 4'b0001 << addr[1:0];
            end
            ALU_STH: begin
                ram_wdata = {2{reg2[15:0]}};
                ram_wstrb = 4'b0011 << {addr[1], 1'b0};
                ale       = addr[0];
            end
            default: ale = 1'b0;
        endcase
    end

    assign ram_we   = (sel == SEL_STORE);
    assign ram_addr = addr[31:2];
    assign ram_en   = issue_valid && (sel == SEL_LOAD || sel == SEL_STORE) && !ale
                      && !(aluop == ALU_SCW && !llb_cur);

    // LL.W sets the LLbit, a successful SC.W clears it.
    always_comb begin
        csr_waddr = 14'd0;
        llb_val   = 1'b0;
        if (aluop == ALU_LLW) begin
            csr_waddr = csr_llbctl;
            llb_val   = 1'b1;
        end else if (aluop == ALU_SCW && llb_cur) begin
            csr_waddr = csr_llbctl;
        end
    end

    always_comb begin
        case (sel)
            SEL_LOGIC: result = logic_res;
            SEL_SHIFT: result = shift_res;
            SEL_ARITH: result = arith_res;
            SEL_STORE: result = (aluop == ALU_SCW) ? {31'd0, llb_cur} : 32'd0;
            default:   result = 32'd0;
        endcase
    end

    assign is_div     = (aluop == ALU_DIV) || (aluop == ALU_DIVU)
                        || (aluop == ALU_MOD) || (aluop == ALU_MODU);
    assign div_start  = issue_valid && is_div;
    assign div_signed = (aluop == ALU_DIV) || (aluop == ALU_MOD);
    assign div_a      = reg1;
    assign div_b      = reg2;
    assign busy       = (state == DIV_WAIT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            em_valid  <= 1'b0;
            em_llb_we <= 1'b0;
        end else begin
            if (div_start) begin
                state <= DIV_WAIT;
            end else if (div_done) begin
                state <= IDLE;
            end
            em_valid  <= (issue_valid && !is_div) || div_done;
            em_llb_we <= issue_valid && (csr_waddr == csr_llbctl) && !ale;
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            div_op <= aluop;
            div_rd <= rd;
        end
        if (div_done) begin
            em_sel      <= SEL_ARITH;
            em_aluop    <= div_op;
            em_rd       <= div_rd;
            em_result   <= (div_op == ALU_DIV || div_op == ALU_DIVU) ? div_q : div_r;
            em_byte_off <= 2'd0;
            em_exc      <= EXC_NONE;
            em_llb_val  <= 1'b0;
        end else begin
            em_sel      <= sel;
            em_aluop    <= aluop;
            em_rd       <= rd;
            em_result   <= result;
            em_byte_off <= addr[1:0];
            em_exc      <= ale ? EXC_ALE : EXC_NONE;
            em_llb_val  <= llb_val;
        end
    end

endmodule

//--- src/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int unsigned ram_words = 256
) (
    input  logic           clk,
    input  logic           ram_en,
    input  logic           ram_we,
    input  logic [29:0]    ram_addr,
    input  logic [3:0]     ram_wstrb,
    input  la_pkg::bus32_t ram_wdata,
    output la_pkg::bus32_t ram_rdata
);

    localparam int unsigned aw = $clog2(ram_words);

    logic [31:0] mem [ram_words] = '{default: 32'h0};
    logic [aw-1:0] idx;

    // Word index wraps inside the RAM.
    assign idx = ram_addr[aw-1:0];

    always_ff @(posedge clk) begin
        if (ram_en) begin
            if (ram_we) begin
                for (int i = 0; i < 4; i++) begin
                    if (ram_wstrb[i]) begin
                        mem[idx][8*i +: 8] <= ram_wdata[8*i +: 8];
                    end
                end
            end else begin
                ram_rdata <= mem[idx];
            end
        end
    end

endmodule

//--- src/div_unit.sv
`timescale 1ns/1ps

module div_unit (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           div_start,
    input  logic           div_signed,
    input  la_pkg::bus32_t div_a,
    input  la_pkg::bus32_t div_b,
    output logic           div_done,
    output la_pkg::bus32_t div_q,
    output la_pkg::bus32_t div_r
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIX
    } state_e;

    state_e      state;
    logic [4:0]  step;
    logic [31:0] quo;
    logic [31:0] rem;
    logic [31:0] dvs;
    logic        neg_q;
    logic        neg_r;
    logic [31:0] a_mag;
    logic [31:0] b_mag;
    logic [32:0] trial;

    assign a_mag = (div_signed && div_a[31]) ? -div_a : div_a;
    assign b_mag = (div_signed && div_b[31]) ? -div_b : div_b;

    // Partial remainder with the next dividend bit shifted in, minus the divisor.
    assign trial = {rem, quo[31]} - {1'b0, dvs};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            step  <= 5'd0;
        end else begin
            case (state)
                IDLE: begin
                    if (div_start) begin
                        state <= RUN;
                        step  <= 5'd0;
                    end
                end
                RUN: begin
                    step <= step + 5'd1;
                    if (step == 5'd31) begin
                        state <= FIX;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && div_start) begin
            quo   <= a_mag;
            rem   <= 32'd0;
            dvs   <= b_mag;
            // A zero divisor keeps the all-ones quotient unsigned.
            neg_q <= div_signed && (div_a[31] ^ div_b[31]) && (div_b != 32'd0);
            neg_r <= div_signed && div_a[31];
        end else if (state == RUN) begin
            if (!trial[32]) begin
                rem <= trial[31:0];
                quo <= {quo[30:0], 1'b1};
            end else begin
                rem <= {rem[30:0], quo[31]};
                quo <= {quo[30:0], 1'b0};
            end
        end
    end

    // Sign correction in the FIX cycle.
    assign div_done = (state == FIX);
    assign div_q    = neg_q ? -quo : quo;
    assign div_r    = neg_r ? -rem : rem;

endmodule

//--- src/la_pkg.sv
package la_pkg;

    typedef logic [31:0] bus32_t;
    typedef logic [63:0] bus64_t;

    // Decoded operation, one code per supported instruction.
    typedef enum logic [4:0] {
        ALU_OR,
        ALU_NOR,
        ALU_AND,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_MUL,
        ALU_MULH,
        ALU_MULHU,
        ALU_DIV,
        ALU_DIVU,
        ALU_MOD,
        ALU_MODU,
        ALU_LDB,
        ALU_LDBU,
        ALU_LDH,
        ALU_LDHU,
        ALU_LDW,
        ALU_LLW,
        ALU_STB,
        ALU_STH,
        ALU_STW,
        ALU_SCW,
        ALU_NOP
    } aluop_e;

    // Result group of an operation.
    typedef enum logic [2:0] {
        SEL_LOGIC,
        SEL_SHIFT,
        SEL_ARITH,
        SEL_LOAD,
        SEL_STORE
    } alusel_e;

    // Exception codes follow the LoongArch ECODE numbering.
    typedef enum logic [6:0] {
        EXC_NONE = 7'h00,
        EXC_ALE  = 7'h09
    } exc_cause_e;

    localparam logic [13:0] csr_llbctl = 14'h060;

endpackage
